// File: hw/shim_pkg.sv
// Shared request word types and lane constants for the TX shim
// Every request word carries its type and line count in the top four bits
// Reads and write beats are two views of one 64-bit word
// Modules import this package inside their bodies
`default_nettype none

package shim_pkg;

    // Word and lane geometry
    localparam int REQ_WORD_WIDTH     = 64;
    localparam int RD_ADDR_WIDTH      = REQ_WORD_WIDTH - 16;
    localparam int WR_DATA_WIDTH      = REQ_WORD_WIDTH - 5;
    localparam int NUM_LANES          = 2;
    localparam int LANE_RD            = 0;
    localparam int LANE_WR            = 1;
    localparam int DEFAULT_LANE_DEPTH = 16;

    // Request type, codes 2 and 3 reserved
    typedef enum logic [1:0]
    {
        REQ_RDLINE = 2'b00,
        REQ_WRLINE = 2'b01
    } t_req_type;

    // Number of lines minus one
    typedef logic [1:0] t_cl_len;

    // Read request header
    typedef struct packed
    {
        t_req_type                req_type;
        t_cl_len                  cl_len;
        logic [11:0]              tag;
        logic [RD_ADDR_WIDTH-1:0] addr;
    } t_rd_hdr;

    // One beat of a write packet
    typedef struct packed
    {
        t_req_type                req_type;
        t_cl_len                  cl_len;
        logic                     sop;
        logic [WR_DATA_WIDTH-1:0] data;
    } t_wr_beat;

    // Type and length sit at the same place in both views
    typedef union packed
    {
        t_rd_hdr  rd;
        t_wr_beat wr;
    } t_req_word;

endpackage

`default_nettype wire

// File: hw/req_dispatch.sv
// Input stage of the TX shim
// Registers each AFU request word and raises the push of the lane picked by its type
// Reserved types are dropped, and all input is dropped once a lane error is set
`timescale 1ns/1ps
`default_nettype none

module req_dispatch
(
    input  logic                           afu_clk,
    input  logic                           afu_softreset,
    input  logic                           afu_req_valid,
    input  shim_pkg::t_req_word            afu_req_word,
    input  logic                           any_error,
    output logic [shim_pkg::NUM_LANES-1:0] lane_push_valid,
    output shim_pkg::t_req_word            lane_push_word
);

    import shim_pkg::*;

    // Input-side write packet tracking, for protocol checking
    logic    in_open;
    t_cl_len in_rem;

    // Steer by request type
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            lane_push_valid <= '0;
        end
        else
        begin
            lane_push_valid <= '0;
            // Nothing gets through after an overflow
            if (afu_req_valid && !any_error)
            begin
                case (afu_req_word.rd.req_type)
                    REQ_RDLINE: lane_push_valid[LANE_RD] <= 1'b1;
                    REQ_WRLINE: lane_push_valid[LANE_WR] <= 1'b1;
                    default:    lane_push_valid <= '0;
                endcase
            end
        end
    end

    // Shared word bus to all lanes
    always_ff @(posedge afu_clk)
    begin
        lane_push_word <= afu_req_word;
    end

    // Count beats still owed by a multi-line write
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            in_open <= 1'b0;
            in_rem  <= '0;
        end
        else if (afu_req_valid && (afu_req_word.wr.req_type == REQ_WRLINE))
        begin
            if (in_open)
            begin
                in_rem  <= in_rem - t_cl_len'(1);
                in_open <= (in_rem != t_cl_len'(1));
            end
            else
            begin
                in_open <= afu_req_word.wr.sop && (afu_req_word.wr.cl_len != '0);
                in_rem  <= afu_req_word.wr.cl_len;
            end
        end
    end

    // Continuation beats only inside an open packet
    wr_beat_in_packet: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        (afu_req_valid && (afu_req_word.wr.req_type == REQ_WRLINE) && !afu_req_word.wr.sop)
        |-> in_open);

endmodule

`default_nettype wire

// File: hw/chan_buffer.sv
// One lane buffer of the TX shim
// Circular buffer of LANE_DEPTH request words with its head word shown to the arbiter
// Returns one AFU credit in the cycle after each pop
// A push into a full buffer is dropped and raises a sticky overflow error
`timescale 1ns/1ps
`default_nettype none

module chan_buffer
#(
    parameter int LANE_DEPTH = shim_pkg::DEFAULT_LANE_DEPTH
)
(
    input  logic                afu_clk,
    input  logic                afu_softreset,
    input  logic                push_valid,
    input  shim_pkg::t_req_word push_word,
    input  logic                pop,
    output logic                ready,
    output shim_pkg::t_req_word head,
    output logic                credit_return,
    output logic                overflow_error
);

    import shim_pkg::*;

    localparam int PTR_W = $clog2(LANE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // Storage and pointers
    t_req_word        mem [LANE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill_cnt;
    logic             full;
    logic             push_ok;

    assign full = (fill_cnt == CNT_W'(LANE_DEPTH));

    // A pop in the same cycle frees the slot
    assign push_ok = push_valid && (!full || pop);

    assign ready = (fill_cnt != '0);
    assign head  = mem[rd_ptr];

    // Word storage
    always_ff @(posedge afu_clk)
    begin
        if (push_ok)
        begin
            mem[wr_ptr] <= push_word;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({push_ok, pop})
                2'b10:   fill_cnt <= fill_cnt + CNT_W'(1);
                2'b01:   fill_cnt <= fill_cnt - CNT_W'(1);
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    // Credit back to the AFU, lines up with fiu_valid for the popped word
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            credit_return <= 1'b0;
        end
        else
        begin
            credit_return <= pop;
        end
    end

    // Overflow stays set until reset
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            overflow_error <= 1'b0;
        end
        else
        begin
            overflow_error <= overflow_error || (push_valid && !push_ok);
        end
    end

    // Arbiter only pops a lane holding a word
    pop_needs_word: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        pop |-> ready);

    // Pointer wrap relies on this
    depth_pow2: assert property (@(posedge afu_clk)
        ((LANE_DEPTH & (LANE_DEPTH - 1)) == 0) && (LANE_DEPTH >= 4));

endmodule

`default_nettype wire

// File: hw/fiu_arbiter.sv
// Output stage of the TX shim
// Picks a ready lane round-robin and registers its head word toward the FIU
// New packets wait while the FIU is almost full, but an open write packet
// runs to its last beat
// Any lane error stops all traffic until reset
`timescale 1ns/1ps
`default_nettype none

module fiu_arbiter
(
    input  logic                           afu_clk,
    input  logic                           afu_softreset,
    input  logic [shim_pkg::NUM_LANES-1:0] lane_ready,
    input  shim_pkg::t_req_word            lane_head [shim_pkg::NUM_LANES],
    input  logic [shim_pkg::NUM_LANES-1:0] lane_error,
    input  logic                           fiu_almfull,
    output logic [shim_pkg::NUM_LANES-1:0] lane_pop,
    output logic                           fiu_valid,
    output shim_pkg::t_req_word            fiu_word
);

    import shim_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);

    logic              any_error;
    logic [LANE_W-1:0] rr_last;
    logic [LANE_W-1:0] rr_cand;
    logic [LANE_W-1:0] grant_idx;
    logic              wr_open;
    t_cl_len           wr_rem;
    t_wr_beat          wr_head;

    assign any_error = |lane_error;

    // Write lane head seen as a write beat
    assign wr_head = lane_head[LANE_WR].wr;

    // Lane choice for this cycle
    always_comb
    begin
        lane_pop  = '0;
        grant_idx = LANE_W'(LANE_WR);
        rr_cand   = rr_last;
        if (!any_error)
        begin
            if (wr_open)
            begin
                // Stay on the write lane until the packet ends, almost-full or not
                lane_pop[LANE_WR] = lane_ready[LANE_WR];
            end
            else if (!fiu_almfull)
            begin
                // Search starts after the last lane served
                for (int i = 1; i <= NUM_LANES; i++)
                begin
                    rr_cand = LANE_W'((int'(rr_last) + i) % NUM_LANES);
                    if ((lane_pop == '0) && lane_ready[rr_cand])
                    begin
                        lane_pop[rr_cand] = 1'b1;
                        grant_idx         = rr_cand;
                    end
                end
            end
        end
    end

    // Round-robin pointer and output valid
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            rr_last   <= '0;
            fiu_valid <= 1'b0;
        end
        else
        begin
            fiu_valid <= |lane_pop;
            if (|lane_pop)
            begin
                rr_last <= grant_idx;
            end
        end
    end

    // Popped head goes straight out
    always_ff @(posedge afu_clk)
    begin
        if (|lane_pop)
        begin
            fiu_word <= lane_head[grant_idx];
        end
    end

    // Remaining beats of the write packet on the wire
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            wr_open <= 1'b0;
            wr_rem  <= '0;
        end
        else if (lane_pop[LANE_WR])
        begin
            if (wr_open)
            begin
                wr_rem  <= wr_rem - t_cl_len'(1);
                wr_open <= (wr_rem != t_cl_len'(1));
            end
            else
            begin
                // Multi-line sop opens a packet
                wr_open <= wr_head.sop && (wr_head.cl_len != '0) &&
                           (wr_head.req_type == REQ_WRLINE);
                wr_rem  <= wr_head.cl_len;
            end
        end
    end

    // Nothing leaves once an error has been seen
    no_output_after_error: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        any_error |=> !fiu_valid);

endmodule

`default_nettype wire

// File: hw/tx_shim_top.sv
// Top level of the TX shim
// AFU request words go through the dispatcher into one buffer per lane,
// and the arbiter drains the lanes toward the FIU
// LANE_DEPTH sets the entries per lane and the AFU's starting credits per lane
`timescale 1ns/1ps
`default_nettype none

module tx_shim_top
#(
    parameter int LANE_DEPTH = shim_pkg::DEFAULT_LANE_DEPTH
)
(
    input  logic                           afu_clk,
    input  logic                           afu_softreset,
    input  logic                           afu_req_valid,
    input  shim_pkg::t_req_word            afu_req_word,
    output logic [shim_pkg::NUM_LANES-1:0] afu_credit_return,
    input  logic                           fiu_almfull,
    output logic                           fiu_valid,
    output shim_pkg::t_req_word            fiu_word,
    output logic [shim_pkg::NUM_LANES-1:0] shim_error
);

    import shim_pkg::*;

    // Dispatcher to lanes
    logic [NUM_LANES-1:0] lane_push_valid;
    t_req_word            lane_push_word;

    // Lanes to arbiter and back
    logic [NUM_LANES-1:0] lane_ready;
    t_req_word            lane_head [NUM_LANES];
    logic [NUM_LANES-1:0] lane_pop;

    req_dispatch dispatch_i
    (
        .afu_clk         (afu_clk),
        .afu_softreset   (afu_softreset),
        .afu_req_valid   (afu_req_valid),
        .afu_req_word    (afu_req_word),
        .any_error       (|shim_error),
        .lane_push_valid (lane_push_valid),
        .lane_push_word  (lane_push_word)
    );

    // One buffer per request type
    generate
        for (genvar g = 0; g < NUM_LANES; g++)
        begin : g_lane
            chan_buffer
            #(
                .LANE_DEPTH (LANE_DEPTH)
            )
            buffer_i
            (
                .afu_clk        (afu_clk),
                .afu_softreset  (afu_softreset),
                .push_valid     (lane_push_valid[g]),
                .push_word      (lane_push_word),
                .pop            (lane_pop[g]),
                .ready          (lane_ready[g]),
                .head           (lane_head[g]),
                .credit_return  (afu_credit_return[g]),
                .overflow_error (shim_error[g])
            );
        end
    endgenerate

    fiu_arbiter arbiter_i
    (
        .afu_clk       (afu_clk),
        .afu_softreset (afu_softreset),
        .lane_ready    (lane_ready),
        .lane_head     (lane_head),
        .lane_error    (shim_error),
        .fiu_almfull   (fiu_almfull),
        .lane_pop      (lane_pop),
        .fiu_valid     (fiu_valid),
        .fiu_word      (fiu_word)
    );

endmodule

`default_nettype wire

// File: verif/tx_shim_tb.sv
// Testbench for the TX shim top level
// Sends credit-respecting random reads and 1 to 4 beat write packets while fiu_almfull toggles,
// then a no-credit burst that overfills the read lane
// Per-lane reference queues feed the concurrent assertions that do the checking
`timescale 1ns/1ps
`default_nettype none

module tx_shim_tb;

    import shim_pkg::*;

    localparam int DEPTH      = 8;
    localparam int ITERS      = 400;
    localparam int WAIT_LIMIT = 400;

    logic                 afu_clk;
    logic                 afu_softreset;
    logic                 afu_req_valid;
    t_req_word            afu_req_word;
    logic [NUM_LANES-1:0] afu_credit_return;
    logic                 fiu_almfull;
    logic                 fiu_valid;
    t_req_word            fiu_word;
    logic [NUM_LANES-1:0] shim_error;

    // Reference model state
    t_req_word rd_q [$];
    t_req_word wr_q [$];
    t_req_word rd_exp;
    t_req_word wr_exp;
    logic      rd_pend;
    logic      wr_pend;
    logic      prev_valid;
    t_req_word prev_word;
    int        pkt_rem;
    int        sent_cnt [NUM_LANES];
    int        ret_cnt [NUM_LANES];

    // Run control
    logic sent_any;
    logic burst_on;
    logic alm_random;
    logic timeout_hit;
    int   err_count;
    int   err_mark;
    int   tests_run;

    tx_shim_top #(.LANE_DEPTH(DEPTH)) dut_i
    (
        .afu_clk           (afu_clk),
        .afu_softreset     (afu_softreset),
        .afu_req_valid     (afu_req_valid),
        .afu_req_word      (afu_req_word),
        .afu_credit_return (afu_credit_return),
        .fiu_almfull       (fiu_almfull),
        .fiu_valid         (fiu_valid),
        .fiu_word          (fiu_word),
        .shim_error        (shim_error)
    );

    always #20 afu_clk = ~afu_clk;

    task automatic flag_error(input string msg);
        err_count++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    // Quiet outputs until the first word goes in
    reset_quiet: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        !sent_any |-> (!fiu_valid && (afu_credit_return == '0) && (shim_error == '0)))
        else flag_error("output active before any word was sent");

    // Each output word matches the head of its lane's reference queue
    order_rd: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        (fiu_valid && (fiu_word.rd.req_type == REQ_RDLINE)) |-> (rd_pend && (fiu_word == rd_exp)))
        else flag_error("read word out of order or corrupted");
    order_wr: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        (fiu_valid && (fiu_word.rd.req_type != REQ_RDLINE))
        |-> ((fiu_word.wr.req_type == REQ_WRLINE) && wr_pend && (fiu_word == wr_exp)))
        else flag_error("write beat out of order or corrupted");

    // Open write packet allows only its own continuation beats
    pkt_contig: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        ((pkt_rem != 0) && fiu_valid) |-> ((fiu_word.wr.req_type == REQ_WRLINE) && !fiu_word.wr.sop))
        else flag_error("write packet interrupted");

    // No new packet in the cycle after almost-full
    almfull_gate: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        fiu_almfull |=> !(fiu_valid && ((fiu_word.rd.req_type == REQ_RDLINE) || fiu_word.wr.sop)))
        else flag_error("new packet started while FIU almost full");

    // Errors only from the deliberate burst, and output stops behind them
    no_early_error: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        !burst_on |-> (shim_error == '0))
        else flag_error("shim_error set while credits were respected");
    quiet_after_error: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        (shim_error != '0) |=> !fiu_valid)
        else flag_error("fiu_valid high after a lane error");

    for (genvar l = 0; l < NUM_LANES; l++)
    begin : g_lane_chk
        localparam t_req_type LTYPE = (l == LANE_RD) ? REQ_RDLINE : REQ_WRLINE;

        // Credit pulse in the same cycle as the word it frees
        credit_match: assert property (@(posedge afu_clk) disable iff (afu_softreset)
            afu_credit_return[l] == (fiu_valid && (fiu_word.rd.req_type == LTYPE)))
            else flag_error($sformatf("credit return mismatch on lane %0d", l));
        credit_bound: assert property (@(posedge afu_clk) disable iff (afu_softreset)
            !burst_on |-> ((sent_cnt[l] >= ret_cnt[l]) && (sent_cnt[l] - ret_cnt[l] <= DEPTH)))
            else flag_error($sformatf("outstanding count out of range on lane %0d", l));
        error_sticky: assert property (@(posedge afu_clk) disable iff (afu_softreset)
            shim_error[l] |=> shim_error[l])
            else flag_error($sformatf("shim_error dropped on lane %0d", l));
    end

    task automatic refresh_heads();
        rd_pend = (rd_q.size() != 0);
        wr_pend = (wr_q.size() != 0);
        if (rd_pend)
        begin
            rd_exp = rd_q[0];
        end
        if (wr_pend)
        begin
            wr_exp = wr_q[0];
        end
    endtask

    // Retire the word shown last cycle, now that its check has run
    task automatic account();
        if (prev_valid && (prev_word.rd.req_type == REQ_RDLINE) && (rd_q.size() != 0))
        begin
            void'(rd_q.pop_front());
        end
        else if (prev_valid && (prev_word.rd.req_type != REQ_RDLINE))
        begin
            if (wr_q.size() != 0)
            begin
                void'(wr_q.pop_front());
            end
            if (pkt_rem != 0)
            begin
                pkt_rem--;
            end
            else if (prev_word.wr.sop)
            begin
                pkt_rem = int'(prev_word.wr.cl_len);
            end
        end
        for (int l = 0; l < NUM_LANES; l++)
        begin
            if (afu_credit_return[l])
            begin
                ret_cnt[l]++;
            end
        end
        prev_valid = fiu_valid && !afu_softreset;
        prev_word  = fiu_word;
        refresh_heads();
    endtask

    // One falling edge: bookkeeping first, then the new inputs
    task automatic drive(input logic valid, input t_req_word word);
        int lane;
        @(negedge afu_clk);
        account();
        afu_req_valid = valid;
        afu_req_word  = word;
        if (alm_random)
        begin
            fiu_almfull = ($urandom_range(0, 3) == 0);
        end
        if (valid)
        begin
            lane = (word.rd.req_type == REQ_RDLINE) ? LANE_RD : LANE_WR;
            if (lane == LANE_RD)
            begin
                rd_q.push_back(word);
            end
            else
            begin
                wr_q.push_back(word);
            end
            sent_cnt[lane]++;
            sent_any = 1'b1;
            refresh_heads();
        end
    endtask

    function automatic t_req_word make_read();
        t_req_word w;
        w.rd.req_type = REQ_RDLINE;
        w.rd.cl_len   = t_cl_len'($urandom_range(0, 3));
        w.rd.tag      = 12'($urandom());
        w.rd.addr     = RD_ADDR_WIDTH'({$urandom(), $urandom()});
        return w;
    endfunction

    function automatic t_req_word make_beat(input int len, input logic first);
        t_req_word w;
        w.wr.req_type = REQ_WRLINE;
        w.wr.cl_len   = t_cl_len'(len);
        w.wr.sop      = first;
        w.wr.data     = WR_DATA_WIDTH'({$urandom(), $urandom()});
        return w;
    endfunction

    // Idle until the lane holds enough credits
    task automatic await_credits(input int lane, input int need);
        int k;
        k = 0;
        while ((DEPTH - (sent_cnt[lane] - ret_cnt[lane]) < need) && (k < WAIT_LIMIT))
        begin
            drive(1'b0, '0);
            k++;
        end
        if (k == WAIT_LIMIT)
        begin
            timeout_hit = 1'b1;
            $display("timeout: lane %0d never returned enough credits", lane);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %s finished with %0d errors", name, err_count - err_mark);
        err_mark = err_count;
    endtask

    initial
    begin
        int len;
        int k;
        void'($urandom(40));
        afu_clk       = 1'b0;
        afu_softreset = 1'b1;
        afu_req_valid = 1'b0;
        afu_req_word  = '0;
        fiu_almfull   = 1'b0;
        prev_valid    = 1'b0;
        prev_word     = '0;
        pkt_rem       = 0;
        sent_any      = 1'b0;
        burst_on      = 1'b0;
        alm_random    = 1'b0;
        timeout_hit   = 1'b0;
        err_count     = 0;
        err_mark      = 0;
        tests_run     = 0;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            sent_cnt[l] = 0;
            ret_cnt[l]  = 0;
        end
        refresh_heads();
        repeat (10) @(negedge afu_clk);
        afu_softreset = 1'b0;

        repeat (8) drive(1'b0, '0);
        end_test("reset_idle");

        // Mixed traffic under random almost-full
        alm_random = 1'b1;
        for (int it = 0; (it < ITERS) && !timeout_hit; it++)
        begin
            case ($urandom_range(0, 3))
                0: drive(1'b0, '0);
                1:
                begin
                    await_credits(LANE_RD, 1);
                    if (!timeout_hit)
                    begin
                        drive(1'b1, make_read());
                    end
                end
                default:
                begin
                    len = $urandom_range(0, 3);
                    await_credits(LANE_WR, len + 1);
                    for (int b = 0; (b <= len) && !timeout_hit; b++)
                    begin
                        drive(1'b1, make_beat(len, b == 0));
                    end
                end
            endcase
        end
        drive(1'b0, '0);
        end_test("random_traffic");

        // Everything sent must come out and every credit come back
        alm_random  = 1'b0;
        fiu_almfull = 1'b0;
        k = 0;
        while (((rd_q.size() + wr_q.size()) != 0 || sent_cnt != ret_cnt) && (k < WAIT_LIMIT))
        begin
            drive(1'b0, '0);
            k++;
        end
        if (k == WAIT_LIMIT)
        begin
            timeout_hit = 1'b1;
            $display("timeout: lanes did not drain or credits were not all returned");
        end
        end_test("drain");

        // Reads with no credits while nothing drains
        if (!timeout_hit)
        begin
            fiu_almfull = 1'b1;
            burst_on    = 1'b1;
            repeat (DEPTH + 4) drive(1'b1, make_read());
            k = 0;
            while (!shim_error[LANE_RD] && (k < WAIT_LIMIT))
            begin
                drive(1'b0, '0);
                k++;
            end
            if (k == WAIT_LIMIT)
            begin
                timeout_hit = 1'b1;
                $display("overflow burst never raised shim_error on the read lane");
            end
            fiu_almfull = 1'b0;
            repeat (12) drive(1'b0, '0);
        end
        end_test("overflow");

        $display("summary: %0d tests run, %0d errors, timeout %0d", tests_run, err_count,
                 timeout_hit);
        if ((err_count == 0) && !timeout_hit)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hw/shim_pkg.sv
hw/req_dispatch.sv
hw/chan_buffer.sv
hw/fiu_arbiter.sv
hw/tx_shim_top.sv
verif/tx_shim_tb.sv

// File: Bender.yml
package:
  name: tx_shim

sources:
  - files:
      - hw/shim_pkg.sv
      - hw/req_dispatch.sv
      - hw/chan_buffer.sv
      - hw/fiu_arbiter.sv
      - hw/tx_shim_top.sv
  - target: test
    files:
      - verif/tx_shim_tb.sv
